// ==== sim.f ====
+incdir+design
+incdir+bench
design/aes_pkg.sv
design/sub_byte.sv
design/key_round.sv
design/cipher_round.sv
design/aes_cipher_top.sv
bench/aes_cipher_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the AES-128 core and its testbench with Verilator, then run the model

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module aes_cipher_tb -f sim.f -o aes_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/aes_sim 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "All tests passed"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== bench/aes_ref.svh ====
//////////////////////////////////////////////////
// Behavioral FIPS-197 AES-128 model, Galois LFSR
//////////////////////////////////////////////////
`ifndef AES_REF_SVH
`define AES_REF_SVH

// Multiply by x modulo x^8 + x^4 + x^3 + x + 1
function automatic logic [7:0] xtime(input logic [7:0] a);
    return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
endfunction

function automatic logic [7:0] gf_product(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] p;
    logic [7:0] x;
    p = 8'h00;
    x = a;
    for (int i = 0; i < 8; i++)
    begin
        if (b[i])
            p = p ^ x;
        x = xtime(x);
    end
    return p;
endfunction

// Inverse by exhaustive search, then the affine step bit by bit
function automatic logic [7:0] sbox_value(input logic [7:0] a);
    logic [7:0] inv;
    logic [7:0] c;
    logic [7:0] s;
    inv = 8'h00;
    c   = 8'h63;
    for (int x = 1; x < 256; x++)
    begin
        if (gf_product(a, 8'(x)) == 8'h01)
            inv = 8'(x);
    end
    for (int i = 0; i < 8; i++)
    begin
        s[i] = inv[i] ^ inv[(i + 4) % 8] ^ inv[(i + 5) % 8]
             ^ inv[(i + 6) % 8] ^ inv[(i + 7) % 8] ^ c[i];
    end
    return s;
endfunction

function automatic logic [127:0] aes_encrypt(input logic [127:0] pt, input logic [127:0] k);
    logic [31:0]  w [0:43];
    logic [7:0]   s [0:15];
    logic [7:0]   t [0:15];
    logic [31:0]  tmp;
    logic [7:0]   rc;
    logic [7:0]   a0;
    logic [7:0]   a1;
    logic [7:0]   a2;
    logic [7:0]   a3;
    logic [127:0] res;
    rc = 8'h01;
    for (int i = 0; i < 4; i++)
        w[i] = k[127 - 32*i -: 32];
    // Key expansion, all 44 words up front
    for (int i = 4; i < 44; i++)
    begin
        tmp = w[i-1];
        if (i % 4 == 0)
        begin
            tmp = {sbox_value(tmp[23:16]), sbox_value(tmp[15:8]),
                   sbox_value(tmp[7:0]), sbox_value(tmp[31:24])} ^ {rc, 24'h000000};
            rc = xtime(rc);
        end
        w[i] = w[i-4] ^ tmp;
    end
    for (int j = 0; j < 16; j++)
        s[j] = pt[127 - 8*j -: 8] ^ w[j / 4][31 - 8*(j % 4) -: 8];
    for (int rnd = 1; rnd <= 10; rnd++)
    begin
        // s[r + 4c] is row r of column c
        for (int j = 0; j < 16; j++)
            t[j] = sbox_value(s[j]);
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
                s[r + 4*c] = t[r + 4*((c + r) % 4)];
        end
        if (rnd < 10)
        begin
            for (int c = 0; c < 4; c++)
            begin
                a0 = s[4*c];
                a1 = s[4*c + 1];
                a2 = s[4*c + 2];
                a3 = s[4*c + 3];
                s[4*c]     = xtime(a0) ^ gf_product(8'h03, a1) ^ a2 ^ a3;
                s[4*c + 1] = a0 ^ xtime(a1) ^ gf_product(8'h03, a2) ^ a3;
                s[4*c + 2] = a0 ^ a1 ^ xtime(a2) ^ gf_product(8'h03, a3);
                s[4*c + 3] = gf_product(8'h03, a0) ^ a1 ^ a2 ^ xtime(a3);
            end
        end
        for (int j = 0; j < 16; j++)
            s[j] = s[j] ^ w[4*rnd + j / 4][31 - 8*(j % 4) -: 8];
    end
    for (int j = 0; j < 16; j++)
        res[127 - 8*j -: 8] = s[j];
    return res;
endfunction

// Right-shift Galois form of x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

`endif

// ==== bench/aes_cipher_tb.sv ====
//////////////////////////////////////////////////
// Testbench for the pipelined AES-128 core
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "aes_consts.svh"

module aes_cipher_tb;
    import aes_pkg::*;

    `include "aes_ref.svh"

    logic       clk = 1'b0;
    logic       rst;
    logic       in_valid;
    aes_block_t plaintext;
    aes_block_t key;
    logic       out_valid;
    aes_block_t ciphertext;

    logic [`AES_BLOCK_BITS-1:0] exp_q [$];
    int                         due_q [$];
    logic [`AES_BLOCK_BITS-1:0] exp_ct;
    logic                       exp_valid;
    logic [31:0]                lfsr;
    int                         cycle_count = 0;

    aes_cipher_top dut0 (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .plaintext  (plaintext),
        .key        (key),
        .out_valid  (out_valid),
        .ciphertext (ciphertext)
    );

    always #10 clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(input string name, input logic [127:0] got,
                                   input logic [127:0] exp);
        fail_run($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                           $time, name, got, exp));
    endtask

    //////////////////////////////////////////////////
    // Scoreboard with arrival cycle per block
    //////////////////////////////////////////////////
    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
    end

    // Mid-cycle sampling, inputs and outputs are settled here
    // A block offered in cycle n is due on the output in cycle n + 21
    always @(negedge clk)
    begin
        exp_valid = (due_q.size() > 0) && (due_q[0] == cycle_count);
        a_valid_timing : assert (out_valid === exp_valid)
        else report_mismatch("out_valid", {127'b0, out_valid}, {127'b0, exp_valid});
        if (exp_valid)
        begin
            void'(due_q.pop_front());
            exp_ct = exp_q.pop_front();
            a_ciphertext : assert (ciphertext == exp_ct)
            else report_mismatch("ciphertext", ciphertext, exp_ct);
        end
        // A block seen with rst high never enters the pipeline
        if (rst)
        begin
            exp_q.delete();
            due_q.delete();
        end
        else if (in_valid === 1'b1)
        begin
            exp_q.push_back(aes_encrypt(plaintext, key));
            due_q.push_back(cycle_count + `AES_LATENCY);
        end
    end

    //////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic random_block(output logic [127:0] v);
        for (int i = 0; i < 128; i++)
        begin
            lfsr = lfsr_next(lfsr);
            v[i] = lfsr[0];
        end
    endtask

    task automatic send_random(input int count, input bit with_gaps);
        logic [127:0] v;
        for (int i = 0; i < count; i++)
        begin
            random_block(v);
            plaintext = v;
            random_block(v);
            key = v;
            lfsr = lfsr_next(lfsr);
            in_valid = with_gaps ? lfsr[0] : 1'b1;
            next_cycle();
        end
        in_valid = 1'b0;
    endtask

    // One block alone in the pipeline, checked against a fixed answer
    task automatic run_known(input logic [127:0] k, input logic [127:0] pt,
                             input logic [127:0] exp);
        int waited;
        key = k;
        plaintext = pt;
        in_valid = 1'b1;
        next_cycle();
        in_valid = 1'b0;
        waited = 1;
        while (out_valid !== 1'b1 && waited < 4 * `AES_LATENCY)
        begin
            next_cycle();
            waited++;
        end
        if (out_valid !== 1'b1)
            fail_run("timeout waiting for out_valid on a known-answer block");
        a_known_latency : assert (waited == `AES_LATENCY)
        else report_mismatch("latency", 128'(waited), 128'(`AES_LATENCY));
        a_known_answer : assert (ciphertext == exp)
        else report_mismatch("ciphertext", ciphertext, exp);
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        next_cycle();
        while (exp_q.size() != 0 && waited < 4 * `AES_LATENCY)
        begin
            next_cycle();
            waited++;
        end
        if (exp_q.size() != 0)
            fail_run("timeout waiting for the pipeline to drain");
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////
    initial
    begin
        rst = 1'b1;
        in_valid = 1'b0;
        plaintext = '0;
        key = '0;
        lfsr = 32'ha7c4_ade5;
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        next_cycle();
        a_idle_after_reset : assert (out_valid === 1'b0)
        else report_mismatch("out_valid", {127'b0, out_valid}, 128'd0);

        // FIPS-197 vectors
        run_known(128'h000102030405060708090a0b0c0d0e0f, 128'h00112233445566778899aabbccddeeff,
                  128'h69c4e0d86a7b0430d8cdb78070b4c55a);
        run_known(128'h2b7e151628aed2a6abf7158809cf4f3c, 128'h3243f6a8885a308d313198a2e0370734,
                  128'h3925841d02dc09fbdc118597196a0b32);
        run_known(128'h0, 128'h0, 128'h66e94bd4ef8a2c3b884cfa59ca342b2e);
        wait_drain();

        // Back-to-back stream, then random gaps
        send_random(30, 1'b0);
        wait_drain();
        send_random(60, 1'b1);
        wait_drain();

        // Reset while blocks are in flight
        send_random(12, 1'b0);
        rst = 1'b1;
        send_random(2, 1'b0);
        rst = 1'b0;
        for (int i = 0; i < `AES_LATENCY; i++)
        begin
            next_cycle();
            a_quiet_after_reset : assert (out_valid === 1'b0)
            else report_mismatch("out_valid", {127'b0, out_valid}, 128'd0);
        end
        send_random(25, 1'b1);
        wait_drain();

        $display("All tests passed");
        $finish;
    end

endmodule

// ==== design/aes_cipher_top.sv ====
//////////////////////////////////////////////////
// Fully pipelined AES-128 encryption core with
// per-block valid tracking
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "aes_consts.svh"

module aes_cipher_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    input  aes_pkg::aes_block_t plaintext,
    input  aes_pkg::aes_block_t key,
    output logic                out_valid,
    output aes_pkg::aes_block_t ciphertext
);
    import aes_pkg::*;

    localparam logic [`AES_BYTE_BITS-1:0] rcon_table [0:`AES_NUM_ROUNDS-1] = '{
        `AES_RCON_1, `AES_RCON_2, `AES_RCON_3, `AES_RCON_4, `AES_RCON_5,
        `AES_RCON_6, `AES_RCON_7, `AES_RCON_8, `AES_RCON_9, `AES_RCON_10
    };

    aes_block_t              state_q;
    aes_block_t              key_q;
    aes_block_t              state_chain [0:`AES_NUM_ROUNDS];
    aes_block_t              key_chain   [0:`AES_NUM_ROUNDS-1];
    aes_block_t              round_keys  [0:`AES_NUM_ROUNDS-1];
    logic [`AES_LATENCY-1:0] valid_chain;

    //////////////////////////////////////////////////
    // Initial AddRoundKey with the cipher key
    //////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        for (int w = 0; w < 4; w++)
        begin
            state_q.words[w] <= plaintext.words[w] ^ key.words[w];
        end
        key_q <= key;
    end

    assign state_chain[0] = state_q;
    assign key_chain[0]   = key_q;

    //////////////////////////////////////////////////
    // Round and key expansion stages
    //////////////////////////////////////////////////
    for (genvar r = 0; r < `AES_NUM_ROUNDS; r++)
    begin : g_round
        // Last stage's next key feeds nothing
        if (r < `AES_NUM_ROUNDS - 1)
        begin : g_key
            key_round #(.rcon(rcon_table[r])) u_key (
                .clk       (clk),
                .key_in    (key_chain[r]),
                .round_key (round_keys[r]),
                .key_out   (key_chain[r+1])
            );
        end
        else
        begin : g_key_last
            key_round #(.rcon(rcon_table[r])) u_key (
                .clk       (clk),
                .key_in    (key_chain[r]),
                .round_key (round_keys[r]),
                .key_out   ()
            );
        end

        cipher_round #(.final_round(r == `AES_NUM_ROUNDS - 1)) u_round (
            .clk       (clk),
            .state_in  (state_chain[r]),
            .round_key (round_keys[r]),
            .state_out (state_chain[r+1])
        );
    end

    assign ciphertext = state_chain[`AES_NUM_ROUNDS];

    // Valid bit follows its block through every register stage
    always_ff @(posedge clk)
    begin
        if (rst)
            valid_chain <= '0;
        else
            valid_chain <= {valid_chain[`AES_LATENCY-2:0], in_valid};
    end

    assign out_valid = valid_chain[`AES_LATENCY-1];

    // Nothing can reach the output before a full pipeline traversal
    a_quiet_after_reset : assert property (
        @(posedge clk) $fell(rst) |-> !out_valid [*`AES_LATENCY]
    );

endmodule

// ==== design/cipher_round.sv ====
//////////////////////////////////////////////////
// One pipelined AES round, full or final
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "aes_consts.svh"

module cipher_round #(
    parameter bit final_round = 1'b0
) (
    input  logic                clk,
    input  aes_pkg::aes_block_t state_in,
    input  aes_pkg::aes_block_t round_key,
    output aes_pkg::aes_block_t state_out
);
    import aes_pkg::*;

    // Byte-wise multiply by x over one column
    function automatic logic [`AES_WORD_BITS-1:0] double_word(
        input logic [`AES_WORD_BITS-1:0] w
    );
        logic [`AES_WORD_BITS-1:0] d;
        for (int k = 0; k < 4; k++)
        begin
            d[8*k +: 8] = {w[8*k +: 7], 1'b0} ^ (w[8*k + 7] ? 8'h1b : 8'h00);
        end
        return d;
    endfunction

    // Each output byte is 2*a(i) ^ 3*a(i+1) ^ a(i+2) ^ a(i+3)
    function automatic logic [`AES_WORD_BITS-1:0] mix_column(
        input logic [`AES_WORD_BITS-1:0] col
    );
        logic [`AES_WORD_BITS-1:0] rot1;
        logic [`AES_WORD_BITS-1:0] rot2;
        logic [`AES_WORD_BITS-1:0] rot3;
        rot1 = {col[23:0], col[31:24]};
        rot2 = {col[15:0], col[31:16]};
        rot3 = {col[7:0], col[31:8]};
        return double_word(col) ^ double_word(rot1) ^ rot1 ^ rot2 ^ rot3;
    endfunction

    aes_block_t sub_state;
    aes_block_t shifted;
    aes_block_t mixed;
    aes_block_t next_state;

    //////////////////////////////////////////////////
    // SubBytes, first pipeline cycle
    //////////////////////////////////////////////////
    for (genvar i = 0; i < 16; i++)
    begin : g_sbox
        sub_byte u_sbox (
            .clk      (clk),
            .in_byte  (state_in.bytes[i]),
            .out_byte (sub_state.bytes[i])
        );
    end

    //////////////////////////////////////////////////
    // ShiftRows, MixColumns, AddRoundKey
    //////////////////////////////////////////////////
    // Row r moves left by r columns
    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
            begin
                shifted.bytes[4*c + r] = sub_state.bytes[4*((c + r) % 4) + r];
            end
        end
    end

    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            if (final_round)
                mixed.words[c] = shifted.words[c];
            else
                mixed.words[c] = mix_column(shifted.words[c]);
            next_state.words[c] = mixed.words[c] ^ round_key.words[c];
        end
    end

    always_ff @(posedge clk)
    begin
        state_out <= next_state;
    end

endmodule

// ==== design/key_round.sv ====
//////////////////////////////////////////////////
// One AES-128 key expansion stage, two cycles
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "aes_consts.svh"

module key_round #(
    parameter logic [`AES_BYTE_BITS-1:0] rcon = 8'h01
) (
    input  logic                clk,
    input  aes_pkg::aes_block_t key_in,
    output aes_pkg::aes_block_t round_key,
    output aes_pkg::aes_block_t key_out
);
    import aes_pkg::*;

    logic [`AES_WORD_BITS-1:0] rot_word;
    logic [`AES_WORD_BITS-1:0] sub_word;
    aes_block_t                prefix_d;
    aes_block_t                prefix_q;
    aes_block_t                next_key;

    // RotWord on the last column
    assign rot_word = {key_in.words[3][23:0], key_in.words[3][31:24]};

    // SubWord, registered inside the S-boxes
    for (genvar b = 0; b < 4; b++)
    begin : g_sbox
        sub_byte u_sbox (
            .clk      (clk),
            .in_byte  (rot_word[`AES_WORD_BITS-1-8*b -: `AES_BYTE_BITS]),
            .out_byte (sub_word[`AES_WORD_BITS-1-8*b -: `AES_BYTE_BITS])
        );
    end

    // Running XOR of the columns, rcon folded into the first one
    always_comb
    begin
        prefix_d.words[0] = key_in.words[0]
                          ^ {rcon, {(`AES_WORD_BITS - `AES_BYTE_BITS){1'b0}}};
        for (int w = 1; w < 4; w++)
        begin
            prefix_d.words[w] = prefix_d.words[w-1] ^ key_in.words[w];
        end
    end

    always_ff @(posedge clk)
    begin
        prefix_q <= prefix_d;
    end

    // Substituted word joins every column of the prefix
    always_comb
    begin
        for (int w = 0; w < 4; w++)
        begin
            next_key.words[w] = prefix_q.words[w] ^ sub_word;
        end
    end

    // Round key is used a cycle early by the matching round
    assign round_key = next_key;

    always_ff @(posedge clk)
    begin
        key_out <= next_key;
    end

endmodule

// ==== design/sub_byte.sv ====
//////////////////////////////////////////////////
// Registered AES S-box, GF inverse plus affine map
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "aes_consts.svh"

module sub_byte (
    input  logic                      clk,
    input  logic [`AES_BYTE_BITS-1:0] in_byte,
    output logic [`AES_BYTE_BITS-1:0] out_byte
);

    // Product in GF(2^8) modulo x^8 + x^4 + x^3 + x + 1
    function automatic logic [`AES_BYTE_BITS-1:0] gf_mul(
        input logic [`AES_BYTE_BITS-1:0] a,
        input logic [`AES_BYTE_BITS-1:0] b
    );
        logic [`AES_BYTE_BITS-1:0] acc;
        logic [`AES_BYTE_BITS-1:0] sh;
        acc = '0;
        sh  = a;
        for (int i = 0; i < `AES_BYTE_BITS; i++)
        begin
            if (b[i])
                acc = acc ^ sh;
            sh = {sh[6:0], 1'b0} ^ (sh[7] ? 8'h1b : 8'h00);
        end
        return acc;
    endfunction

    // a^254 is the inverse, and zero stays zero
    function automatic logic [`AES_BYTE_BITS-1:0] gf_inv(input logic [`AES_BYTE_BITS-1:0] a);
        logic [`AES_BYTE_BITS-1:0] sq;
        logic [`AES_BYTE_BITS-1:0] acc;
        sq  = a;
        acc = 8'h01;
        for (int i = 1; i < `AES_BYTE_BITS; i++)
        begin
            sq  = gf_mul(sq, sq);
            acc = gf_mul(acc, sq);
        end
        return acc;
    endfunction

    logic [`AES_BYTE_BITS-1:0] inv;
    logic [`AES_BYTE_BITS-1:0] affine;

    assign inv = gf_inv(in_byte);
    // Affine map, rotations by 1 to 4 then the constant
    assign affine = inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]}
                  ^ {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;

    always_ff @(posedge clk)
    begin
        out_byte <= affine;
    end

    a_zero_maps_to_63 : assert property (@(posedge clk) in_byte == 8'h00 |=> out_byte == 8'h63);

endmodule

// ==== design/aes_pkg.sv ====
//////////////////////////////////////////////////
// Block type shared by the AES-128 core
//////////////////////////////////////////////////
`include "aes_consts.svh"

package aes_pkg;

    // One 128-bit block seen as columns or as bytes
    // Index 0 is the most significant in both views, so byte 4*c+r
    // is row r of column c, as in the FIPS-197 input ordering
    typedef union packed {
        logic [0:3][`AES_WORD_BITS-1:0]  words;
        logic [0:15][`AES_BYTE_BITS-1:0] bytes;
    } aes_block_t;

endpackage

// ==== design/aes_consts.svh ====
//////////////////////////////////////////////////
// AES-128 widths, round count, pipeline latency
// and round-constant bytes
//////////////////////////////////////////////////
`ifndef AES_CONSTS_SVH
`define AES_CONSTS_SVH

`define AES_BLOCK_BITS   128
`define AES_WORD_BITS    32
`define AES_BYTE_BITS    8
`define AES_NUM_ROUNDS   10
`define AES_STAGE_CYCLES 2
// Whitening register plus two cycles per round
`define AES_LATENCY      (1 + `AES_NUM_ROUNDS * `AES_STAGE_CYCLES)

// Round constants, powers of x in GF(2^8)
`define AES_RCON_1  8'h01
`define AES_RCON_2  8'h02
`define AES_RCON_3  8'h04
`define AES_RCON_4  8'h08
`define AES_RCON_5  8'h10
`define AES_RCON_6  8'h20
`define AES_RCON_7  8'h40
`define AES_RCON_8  8'h80
`define AES_RCON_9  8'h1b
`define AES_RCON_10 8'h36

`endif
